/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_memory_system
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing -Wall --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
src/mem_pkg.sv
src/bus_pkg.sv
src/cache.sv
src/mem_arbiter.sv
src/main_memory.sv
src/memory_system.sv
sim/mem_arbiter_chk.sv
sim/tb_memory_system.sv

/* sim/mem_arbiter_chk.sv */
`timescale 1ns/1ps

module mem_arbiter_chk (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         gnt_i,
    input logic                         gnt_d,
    input logic [bus_pkg::CREDIT_W-1:0] credit_cnt,
    input bus_pkg::mem_req_t            mem_req,
    input logic                         mem_src,
    input bus_pkg::mem_rsp_t            mem_rsp
);

    logic [bus_pkg::MEM_LATENCY-1:0] issue_hist;    // bus issues over the last cycles

    // an issue stays in memory until its credit returns MEM_LATENCY cycles later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_hist <= '0;
        end else begin
            issue_hist <= {issue_hist[bus_pkg::MEM_LATENCY-2:0], mem_req.valid};
        end
    end

    // no grant while memory is full
    grant_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        (gnt_i || gnt_d) |-> ($countones(issue_hist) < bus_pkg::MEM_CREDITS))
        else $error("grant issued while memory already holds its request limit");

    // one winner per cycle
    single_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(gnt_i && gnt_d))
        else $error("both caches granted in one cycle");

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= bus_pkg::CREDIT_W'(bus_pkg::MEM_CREDITS))
        else $error("credit count above its limit");

    // read data comes back to the requester after the fixed latency
    read_response: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.valid && !mem_req.we) |-> ##(bus_pkg::MEM_LATENCY)
        (mem_rsp.valid && (mem_rsp.src == $past(mem_src, bus_pkg::MEM_LATENCY))))
        else $error("read response missing or on the wrong source");

endmodule

/* sim/tb_memory_system.sv */
`timescale 1ns/1ps

module tb_memory_system;

    localparam int CLK_PERIOD  = 4;                         // ns
    localparam int NUM_WORDS   = 1 << mem_pkg::ADDR_W;      // whole memory
    localparam int N_RAND      = 300;                       // random data rounds, up to 3 ops each
    localparam int N_HIT       = 20;                        // same-line read pairs per port
    localparam int N_CONT      = 200;                       // ops per port under contention
    localparam int TOTAL_OPS   = NUM_WORDS + NUM_WORDS / 2 + 3 * N_RAND
                                 + 4 * N_HIT + 2 * N_CONT + 16;
    localparam longint TIMEOUT_NS = longint'(TOTAL_OPS) * 40 * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    bus_pkg::cpu_req_t instr_req;
    bus_pkg::cpu_req_t data_req;
    mem_pkg::word_t    instr_rdata;
    mem_pkg::word_t    data_rdata;
    logic              instr_stall;
    logic              data_stall;

    mem_pkg::word_t model [NUM_WORDS];                      // expected memory image

    memory_system dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req   (instr_req),
        .data_req    (data_req),
        .instr_rdata (instr_rdata),
        .data_rdata  (data_rdata),
        .instr_stall (instr_stall),
        .data_stall  (data_stall)
    );

    bind mem_arbiter mem_arbiter_chk u_arbiter_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .gnt_i      (gnt_i),
        .gnt_d      (gnt_d),
        .credit_cnt (credit_cnt),
        .mem_req    (mem_req),
        .mem_src    (mem_src),
        .mem_rsp    (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hang guard sized from the op count
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, an access never completed", TIMEOUT_NS);
        abort_run();
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_fetch(input mem_pkg::waddr_t a, input mem_pkg::word_t got,
                               input mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error: instr_rdata addr=%h got=%h exp=%h", a, got, exp);
            abort_run();
        end
    endtask

    task automatic check_load(input mem_pkg::waddr_t a, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error: data_rdata addr=%h got=%h exp=%h", a, got, exp);
            abort_run();
        end
    endtask

    task automatic check_stall(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got=%h exp=%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic mem_pkg::waddr_t rand_instr_addr();
        return mem_pkg::waddr_t'($urandom_range(NUM_WORDS / 2 - 1, 0)); // lower half
    endfunction

    function automatic mem_pkg::waddr_t rand_data_addr();
        return mem_pkg::waddr_t'($urandom_range(NUM_WORDS - 1, NUM_WORDS / 2)); // upper half
    endfunction

    function automatic mem_pkg::word_t rand_word();
        return mem_pkg::word_t'($urandom);
    endfunction

    // one instruction read, held until stall drops
    task automatic fetch(input mem_pkg::waddr_t a, output logic first_stall);
        bus_pkg::cpu_req_t r;
        r           = '0;
        r.en        = 1'b1;
        r.addr.flat = a;
        @(posedge clk);
        instr_req <= r;
        @(negedge clk);
        first_stall = instr_stall;                          // low here means a hit
        while (instr_stall) @(negedge clk);
        check_fetch(a, instr_rdata, model[a]);
    endtask

    // one data load or store, held until stall drops
    task automatic data_access(input logic we, input mem_pkg::waddr_t a,
                               input mem_pkg::word_t wd, output logic first_stall);
        bus_pkg::cpu_req_t r;
        r           = '0;
        r.en        = 1'b1;
        r.we        = we;
        r.addr.flat = a;
        r.wdata     = wd;
        @(posedge clk);
        data_req <= r;
        @(negedge clk);
        first_stall = data_stall;
        while (data_stall) @(negedge clk);
        if (we) begin
            model[a] = wd;                                  // store done at its grant
        end else begin
            check_load(a, data_rdata, model[a]);
        end
    endtask

    task automatic release_instr();
        @(posedge clk);
        instr_req <= '0;                                    // last access consumed here
    endtask

    task automatic release_data();
        @(posedge clk);
        data_req <= '0;
    endtask

    task automatic apply_reset();
        rst_n     <= 1'b0;
        instr_req <= '0;
        data_req  <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_stall("instr_stall after reset", instr_stall, 1'b0); // enables are low
        check_stall("data_stall after reset", data_stall, 1'b0);
    endtask

    initial begin
        mem_pkg::waddr_t a;
        logic            st;
        void'($urandom(32'h356d));
        rst_n     = 1'b0;
        instr_req = '0;
        data_req  = '0;
        apply_reset();

        // preload every word through the data port
        for (int i = 0; i < NUM_WORDS; i++) begin
            data_access(1'b1, mem_pkg::waddr_t'(i), rand_word(), st);
        end
        release_data();
        for (int i = 0; i < NUM_WORDS / 2; i++) begin
            fetch(mem_pkg::waddr_t'(i), st);                // miss on offset 0, then hits
        end
        release_instr();

        // random loads and stores in the data region
        for (int n = 0; n < N_RAND; n++) begin
            a = rand_data_addr();
            case ($urandom_range(3, 0))
                0: data_access(1'b1, a, rand_word(), st);
                1: data_access(1'b0, a, '0, st);
                2: begin
                    data_access(1'b1, a, rand_word(), st);  // line maybe not cached
                    data_access(1'b0, a, '0, st);
                end
                default: begin
                    data_access(1'b0, a, '0, st);           // bring the line in first
                    data_access(1'b1, a, rand_word(), st);
                    data_access(1'b0, a, '0, st);
                end
            endcase
        end
        release_data();

        // second read in the same line must hit at once
        for (int n = 0; n < N_HIT; n++) begin
            a = rand_data_addr();
            data_access(1'b0, a, '0, st);
            a[mem_pkg::OFFSET_W-1:0] = mem_pkg::OFFSET_W'($urandom);
            data_access(1'b0, a, '0, st);
            check_stall("data_stall on same-line read", st, 1'b0);
            a = rand_instr_addr();
            fetch(a, st);
            a[mem_pkg::OFFSET_W-1:0] = mem_pkg::OFFSET_W'($urandom);
            fetch(a, st);
            check_stall("instr_stall on same-line read", st, 1'b0);
        end
        release_data();
        release_instr();

        apply_reset();                                      // caches cold again, memory kept

        // both ports busy together
        fork
            begin : instr_side
                logic ist;
                for (int n = 0; n < N_CONT; n++) begin
                    fetch(rand_instr_addr(), ist);
                end
                release_instr();
            end
            begin : data_side
                logic dst;
                for (int n = 0; n < N_CONT; n++) begin
                    if ($urandom_range(1, 0) == 1) begin
                        data_access(1'b1, rand_data_addr(), rand_word(), dst);
                    end else begin
                        data_access(1'b0, rand_data_addr(), '0, dst);
                    end
                end
                release_data();
            end
        join

        repeat (2 * bus_pkg::MEM_LATENCY) @(posedge clk);   // let the last credits drain
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* src/bus_pkg.sv */
package bus_pkg;

    localparam int MEM_LATENCY = 3;                     // issue to response in cycles
    localparam int MEM_CREDITS = 2;                     // max requests in flight at memory
    localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1); // counter holds 0 to MEM_CREDITS

    // processor side access held until stall drops
    typedef struct packed {
        logic            en;                            // access present
        logic            we;                            // store when set
        mem_pkg::addr_u  addr;                          // word address
        mem_pkg::word_t  wdata;                         // store data
    } cpu_req_t;

    // one request on the shared memory bus
    typedef struct packed {
        logic            valid;                         // request present
        logic            we;                            // write when set
        mem_pkg::addr_u  addr;                          // word address
        mem_pkg::word_t  wdata;                         // write data
    } mem_req_t;

    // read data coming back from memory
    typedef struct packed {
        logic            valid;                         // read data present
        logic            src;                           // 0 instr cache and 1 data cache
        mem_pkg::word_t  rdata;                         // returned word
    } mem_rsp_t;

endpackage

/* src/cache.sv */
`timescale 1ns/1ps

module cache (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::cpu_req_t req,
    input  logic              mem_gnt,
    input  bus_pkg::mem_rsp_t mem_rsp,
    output mem_pkg::word_t    rdata,
    output logic              stall,
    output bus_pkg::mem_req_t mem_req
);

    mem_pkg::word_t data_q [mem_pkg::NUM_LINES][mem_pkg::WORDS_PER_LINE]; // line data
    logic [mem_pkg::TAG_W-1:0] tag_q [mem_pkg::NUM_LINES];               // line tags
    logic [mem_pkg::NUM_LINES-1:0] valid_q;                              // line valid bits

    logic [mem_pkg::OFFSET_W:0] issued_cnt;     // fill words sent to the bus
    logic [mem_pkg::OFFSET_W:0] recv_cnt;       // fill words returned
    logic [mem_pkg::OFFSET_W:0] in_flight;      // sent but not yet back

    logic [mem_pkg::TAG_W-1:0]    tag;
    logic [mem_pkg::INDEX_W-1:0]  index;
    logic [mem_pkg::OFFSET_W-1:0] offset;

    logic line_match;                           // valid line with matching tag
    logic rd_req;
    logic wr_req;
    logic rd_miss;
    logic fill_req;                             // fill word ready to go out
    logic fill_done;                            // last fill word arriving
    logic store_hit;                            // granted store onto a cached line

    // split the request address into cache fields
    assign tag    = req.addr.fields.tag;
    assign index  = req.addr.fields.index;
    assign offset = req.addr.fields.offset;

    assign line_match = valid_q[index] && (tag_q[index] == tag); // combinational tag compare
    assign rd_req     = req.en && !req.we;
    assign wr_req     = req.en && req.we;
    assign rd_miss    = rd_req && !line_match;

    assign in_flight = issued_cnt - recv_cnt;
    // top bit of issued_cnt marks all four words sent
    assign fill_req  = rd_miss && !issued_cnt[mem_pkg::OFFSET_W]
                       && (in_flight < (mem_pkg::OFFSET_W + 1)'(bus_pkg::MEM_CREDITS));
    assign fill_done = mem_rsp.valid && (recv_cnt[mem_pkg::OFFSET_W-1:0] == '1);
    assign store_hit = wr_req && mem_gnt && line_match;

    assign rdata = data_q[index][offset];       // valid whenever the read hits
    // reads wait for the line and stores wait for their grant
    assign stall = rd_miss || (wr_req && !mem_gnt);

    always_comb begin
        mem_req                     = '0;
        mem_req.valid               = fill_req || wr_req; // stores go straight through
        mem_req.we                  = wr_req;
        mem_req.addr.fields.tag     = tag;
        mem_req.addr.fields.index   = index;
        mem_req.addr.fields.offset  = wr_req ? offset
                                             : issued_cnt[mem_pkg::OFFSET_W-1:0]; // next fill word
        mem_req.wdata               = req.wdata;
    end

    // fill sequencer counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issued_cnt <= '0;
            recv_cnt   <= '0;
        end else if (fill_done) begin
            issued_cnt <= '0;                   // ready for the next fill
            recv_cnt   <= '0;
        end else begin
            if (fill_req && mem_gnt) begin
                issued_cnt <= issued_cnt + 1'b1;
            end
            if (mem_rsp.valid) begin
                recv_cnt <= recv_cnt + 1'b1;    // responses come back in issue order
            end
        end
    end

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (mem_rsp.valid) begin
            data_q[index][recv_cnt[mem_pkg::OFFSET_W-1:0]] <= mem_rsp.rdata; // fill word
        end else if (store_hit) begin
            data_q[index][offset] <= req.wdata; // write through keeps the line current
        end
        if (fill_done) begin
            tag_q[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_done) begin
            valid_q[index] <= 1'b1;             // whole line now present
        end else if (mem_rsp.valid && (recv_cnt == '0)) begin
            valid_q[index] <= 1'b0;             // old line is being overwritten
        end
    end

endmodule

/* src/main_memory.sv */
`timescale 1ns/1ps

module main_memory (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::mem_req_t mem_req,
    input  logic              mem_src,
    output bus_pkg::mem_rsp_t mem_rsp,
    output logic              credit_return
);

    mem_pkg::word_t mem_q [1 << mem_pkg::ADDR_W];           // 1024 words

    logic [bus_pkg::MEM_LATENCY-1:0] vld_q;                 // any request per stage
    logic [bus_pkg::MEM_LATENCY-1:0] rd_q;                  // read request per stage
    logic [bus_pkg::MEM_LATENCY-1:0] src_q;                 // requester per stage
    mem_pkg::word_t                  data_q [bus_pkg::MEM_LATENCY]; // read data per stage

    // array access on the issue edge
    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_req.we) begin
            mem_q[mem_req.addr.flat] <= mem_req.wdata;
        end
    end

    // control stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
            rd_q  <= '0;
        end else begin
            vld_q <= {vld_q[bus_pkg::MEM_LATENCY-2:0], mem_req.valid};
            rd_q  <= {rd_q[bus_pkg::MEM_LATENCY-2:0], mem_req.valid && !mem_req.we};
        end
    end

    // payload stages
    always_ff @(posedge clk) begin
        src_q     <= {src_q[bus_pkg::MEM_LATENCY-2:0], mem_src};
        data_q[0] <= mem_q[mem_req.addr.flat];              // sampled at issue
        for (int i = 1; i < bus_pkg::MEM_LATENCY; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    always_comb begin
        mem_rsp.valid = rd_q[bus_pkg::MEM_LATENCY-1];       // writes return no data
        mem_rsp.src   = src_q[bus_pkg::MEM_LATENCY-1];
        mem_rsp.rdata = data_q[bus_pkg::MEM_LATENCY-1];
    end

    assign credit_return = vld_q[bus_pkg::MEM_LATENCY-1];   // every request frees its slot

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::mem_req_t req_i,
    input  bus_pkg::mem_req_t req_d,
    input  bus_pkg::mem_rsp_t mem_rsp,
    input  logic              credit_return,
    output logic              gnt_i,
    output logic              gnt_d,
    output bus_pkg::mem_rsp_t rsp_i,
    output bus_pkg::mem_rsp_t rsp_d,
    output bus_pkg::mem_req_t mem_req,
    output logic              mem_src
);

    logic [bus_pkg::CREDIT_W-1:0] credit_cnt;   // free slots at memory
    logic                         last_d;       // data cache won the last grant
    logic                         can_issue;
    logic                         issue;

    assign can_issue = (credit_cnt != '0);

    // round robin between the two caches
    assign gnt_i = can_issue && req_i.valid && (!req_d.valid || last_d);
    assign gnt_d = can_issue && req_d.valid && (!req_i.valid || !last_d);
    assign issue = gnt_i || gnt_d;

    always_comb begin
        mem_req       = gnt_d ? req_d : req_i;  // winner drives the bus
        mem_req.valid = issue;
    end

    assign mem_src = gnt_d;                     // tag so the response finds its way home

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_d <= 1'b0;
        end else if (issue) begin
            last_d <= gnt_d;
        end
    end

    // credit counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= bus_pkg::CREDIT_W'(bus_pkg::MEM_CREDITS); // start full
        end else if (issue && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;    // one more in flight
        end else if (!issue && credit_return) begin
            credit_cnt <= credit_cnt + 1'b1;    // memory freed a slot
        end
    end

    // route the response by its source bit
    always_comb begin
        rsp_i       = mem_rsp;
        rsp_i.valid = mem_rsp.valid && !mem_rsp.src;
        rsp_d       = mem_rsp;
        rsp_d.valid = mem_rsp.valid && mem_rsp.src;
    end

endmodule

/* src/mem_pkg.sv */
package mem_pkg;

    localparam int DATA_W = 16;                         // bits per word
    localparam int ADDR_W = 10;                         // word address bits for 1024 words

    localparam int OFFSET_W = 2;                        // word within line
    localparam int INDEX_W  = 3;                        // line select
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // remaining upper bits

    localparam int WORDS_PER_LINE = 1 << OFFSET_W;      // 4 words per line
    localparam int NUM_LINES      = 1 << INDEX_W;       // 8 lines per cache

    typedef logic [DATA_W-1:0] word_t;                  // one data word
    typedef logic [ADDR_W-1:0] waddr_t;                 // one word address

    // cache view of a word address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;                       // upper bits kept in the tag array
        logic [INDEX_W-1:0]  index;                     // picks the line
        logic [OFFSET_W-1:0] offset;                    // picks the word in the line
    } addr_fields_t;

    // same ten bits seen flat by memory or split by the cache
    typedef union packed {
        waddr_t       flat;                             // plain word address
        addr_fields_t fields;                           // tag index offset split
    } addr_u;

endpackage

/* src/memory_system.sv */
`timescale 1ns/1ps

module memory_system (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::cpu_req_t instr_req,
    input  bus_pkg::cpu_req_t data_req,
    output mem_pkg::word_t    instr_rdata,
    output mem_pkg::word_t    data_rdata,
    output logic              instr_stall,
    output logic              data_stall
);

    bus_pkg::mem_req_t i_mem_req;       // instr cache to arbiter
    bus_pkg::mem_req_t d_mem_req;       // data cache to arbiter
    bus_pkg::mem_req_t mem_req;         // arbiter to memory
    bus_pkg::mem_rsp_t i_mem_rsp;
    bus_pkg::mem_rsp_t d_mem_rsp;
    bus_pkg::mem_rsp_t mem_rsp;         // memory to arbiter
    logic              gnt_i;
    logic              gnt_d;
    logic              mem_src;
    logic              credit_return;

    cache i_cache (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (instr_req),
        .mem_gnt (gnt_i),
        .mem_rsp (i_mem_rsp),
        .rdata   (instr_rdata),
        .stall   (instr_stall),
        .mem_req (i_mem_req)
    );

    cache d_cache (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (data_req),
        .mem_gnt (gnt_d),
        .mem_rsp (d_mem_rsp),
        .rdata   (data_rdata),
        .stall   (data_stall),
        .mem_req (d_mem_req)
    );

    mem_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (i_mem_req),
        .req_d         (d_mem_req),
        .mem_rsp       (mem_rsp),
        .credit_return (credit_return),
        .gnt_i         (gnt_i),
        .gnt_d         (gnt_d),
        .rsp_i         (i_mem_rsp),
        .rsp_d         (d_mem_rsp),
        .mem_req       (mem_req),
        .mem_src       (mem_src)
    );

    main_memory u_memory (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req       (mem_req),
        .mem_src       (mem_src),
        .mem_rsp       (mem_rsp),
        .credit_return (credit_return)
    );

endmodule
